//--- Makefile
TOOL      = verilator
FLAGS     = --binary --assert --timescale 1ns/100ps -Wno-fatal -j 0
TOP       = tb_dma_subsystem
FILELIST  = dma_subsystem.f
BUILD_DIR = obj_dir
PASS_MSG  = Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- dma_subsystem.f
+incdir+verilog
verilog/dma_bus_pkg.sv
verilog/dma_ctrl_pkg.sv
verilog/dma_controller.sv
verilog/bus_arbiter.sv
verilog/ext_device.sv
verilog/word_memory.sv
verilog/dma_subsystem.sv
testbench/tb_dma_subsystem.sv

//--- testbench/tb_dma_subsystem.sv
`include "dma_consts.svh"

module tb_dma_subsystem;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int num_cmds = 20;
	// per command budget, reset, reset reads and readback of each burst with its neighbours
	localparam int max_cycles = 5 + 8 + num_cmds * (200 + `DMA_DEV_DEPTH + 2);

	logic clk;
	logic reset_n;
	logic cpu_valid;
	dma_ctrl_pkg::dma_cmd_t cpu_cmd;
	logic cpu_hold;
	dma_bus_pkg::mem_read_req_t cpu_read;
	logic dev_load;
	dma_ctrl_pkg::offset_t dev_index;
	dma_bus_pkg::word_t dev_load_data;
	logic interrupt;
	logic bus_request;
	dma_bus_pkg::mem_read_rsp_t cpu_rdata;

	// reference memory and a copy of the device buffer
	dma_bus_pkg::word_t model_mem [`DMA_MEM_DEPTH];
	dma_bus_pkg::word_t model_dev [`DMA_DEV_DEPTH];
	integer seed;
	int errors;
	int irq_total;

	dma_subsystem u_dma_subsystem (
		.clk           (clk),
		.reset_n       (reset_n),
		.cpu_valid     (cpu_valid),
		.cpu_cmd       (cpu_cmd),
		.cpu_hold      (cpu_hold),
		.cpu_read      (cpu_read),
		.dev_load      (dev_load),
		.dev_index     (dev_index),
		.dev_load_data (dev_load_data),
		.interrupt     (interrupt),
		.bus_request   (bus_request),
		.cpu_rdata     (cpu_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// interrupts counted mid cycle, away from the active edge
	always @(negedge clk) begin
		if (reset_n && interrupt) begin
			irq_total++;
		end
	end

	// watchdog
	initial begin
		repeat (max_cycles) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", max_cycles);
		$display("Result: FAILED");
		$finish;
	end

	// inputs change 1 ns after the edge, outputs are read there too
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic check_word(string name, dma_bus_pkg::word_t expected,
		dma_bus_pkg::word_t actual);
		if (expected !== actual) begin
			errors++;
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_bit(string name, logic expected, logic actual);
		if (expected !== actual) begin
			errors++;
			$display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic check_count(string name, int expected, int actual);
		if (expected != actual) begin
			errors++;
			$display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	// byte address to model word, wrapping over the memory depth
	function automatic int word_index(dma_bus_pkg::addr_t addr);
		return (int'(addr) >> 2) % `DMA_MEM_DEPTH;
	endfunction

	// single cpu read, the response is due one cycle later
	task automatic read_check(string name, dma_bus_pkg::addr_t addr,
		dma_bus_pkg::word_t expected);
		cpu_read.rd_en = 1'b1;
		cpu_read.addr = addr;
		next_cycle();
		cpu_read = '0;
		check_bit({name, " read valid"}, 1'b1, cpu_rdata.valid);
		check_word({name, " read data"}, expected, cpu_rdata.data);
	endtask

	task automatic run_command(int n);
		dma_bus_pkg::addr_t start;
		dma_bus_pkg::addr_t addr;
		int words;
		int hold;
		int irq_before;
		string name;
		name = $sformatf("cmd%0d", n);
		start = dma_bus_pkg::addr_t'($random(seed));
		words = ($unsigned($random(seed)) % `DMA_DEV_DEPTH) + 1;
		hold = $unsigned($random(seed)) % 21;
		irq_before = irq_total;
		// fresh device contents for every burst
		for (int i = 0; i < `DMA_DEV_DEPTH; i++) begin
			dev_load = 1'b1;
			dev_index = dma_ctrl_pkg::offset_t'(i);
			dev_load_data = dma_bus_pkg::word_t'($random(seed));
			model_dev[i] = dev_load_data;
			next_cycle();
		end
		dev_load = 1'b0;
		cpu_valid = 1'b1;
		cpu_cmd.start_addr = start;
		cpu_cmd.length = dma_bus_pkg::addr_t'(words * 4);
		cpu_hold = (hold != 0);
		next_cycle();
		cpu_valid = 1'b0;
		// cpu keeps the bus, request waits and nothing completes
		for (int i = 0; i < hold; i++) begin
			check_bit({name, " request during hold"}, 1'b1, bus_request);
			check_bit({name, " interrupt during hold"}, 1'b0, interrupt);
			next_cycle();
		end
		cpu_hold = 1'b0;
		// odd commands get a second pulse while busy, it has to be dropped
		if (n % 2 == 1) begin
			check_bit({name, " busy at second pulse"}, 1'b1, bus_request);
			cpu_valid = 1'b1;
			cpu_cmd.start_addr = dma_bus_pkg::addr_t'($random(seed));
			cpu_cmd.length = 16'd64;
			next_cycle();
			cpu_valid = 1'b0;
		end
		while (interrupt !== 1'b1) begin
			next_cycle();
		end
		check_bit({name, " request at interrupt"}, 1'b0, bus_request);
		next_cycle();
		check_bit({name, " interrupt width"}, 1'b0, interrupt);
		for (int i = 0; i < words; i++) begin
			model_mem[word_index(start + dma_bus_pkg::addr_t'(4 * i))] = model_dev[i];
		end
		// burst plus the word on each side of it
		for (int i = -1; i <= words; i++) begin
			addr = start + dma_bus_pkg::addr_t'(4 * i);
			read_check(name, addr, model_mem[word_index(addr)]);
		end
		check_count({name, " interrupt total"}, irq_before + 1, irq_total);
	endtask

	initial begin
		seed = 35990;
		errors = 0;
		irq_total = 0;
		reset_n = 1'b0;
		cpu_valid = 1'b0;
		cpu_cmd = '0;
		cpu_hold = 1'b0;
		cpu_read = '0;
		dev_load = 1'b0;
		dev_index = '0;
		dev_load_data = '0;
		for (int i = 0; i < `DMA_MEM_DEPTH; i++) begin
			model_mem[i] = '0;
		end
		repeat (5) @(posedge clk);
		#1;
		reset_n = 1'b1;
		check_bit("reset interrupt", 1'b0, interrupt);
		check_bit("reset request", 1'b0, bus_request);
		// memory comes out of reset cleared
		for (int i = 0; i < 8; i++) begin
			read_check("reset", dma_bus_pkg::addr_t'($random(seed)), '0);
		end
		for (int n = 0; n < num_cmds; n++) begin
			run_command(n);
		end
		$display("errors %0d, interrupts %0d of %0d", errors, irq_total, num_cmds);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- verilog/bus_arbiter.sv
module bus_arbiter (
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic                       bus_request,
	input  logic                       cpu_hold,
	input  logic                       ex_valid,
	input  dma_bus_pkg::addr_t         dma_address,
	input  dma_bus_pkg::word_t         dev_data,
	input  dma_bus_pkg::mem_read_req_t cpu_read,
	output logic                       bus_grant,
	output dma_bus_pkg::mem_write_t    mem_wr,
	output dma_bus_pkg::mem_read_req_t mem_rd
);

	// registered grant
	// cpu_hold only matters before the grant is given
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			bus_grant <= 1'b0;
		end else if (bus_grant) begin
			// release one cycle after the request drops
			bus_grant <= bus_request;
		end else begin
			bus_grant <= bus_request && !cpu_hold;
		end
	end

	// dma owns the write path while granted
	always_comb begin
		mem_wr = '0;
		if (bus_grant) begin
			mem_wr.wr_en = ex_valid;
			mem_wr.addr = dma_address;
			mem_wr.data = dev_data;
		end
	end

	// cpu reads only reach memory while the dma is off the bus
	always_comb begin
		mem_rd = '0;
		if (!bus_grant) begin
			mem_rd = cpu_read;
		end
	end

	// no cpu read gets through while the dma has a word waiting for the bus
	a_no_wr_rd_overlap: assert property (@(posedge clk) disable iff (!reset_n)
		!(ex_valid && mem_rd.rd_en));

endmodule

//--- verilog/dma_bus_pkg.sv
`include "dma_consts.svh"

package dma_bus_pkg;

	// one data word on the memory bus
	typedef logic [`DMA_WORD_SIZE-1:0] word_t;

	// byte address, memory uses bits above the low two
	typedef logic [`DMA_WORD_SIZE-1:0] addr_t;

	// write request from the granted master
	// strobe stays high until the acknowledge
	typedef struct packed {
		logic wr_en;
		addr_t addr;
		word_t data;
	} mem_write_t;

	// cpu read request, one cycle strobe
	typedef struct packed {
		logic rd_en;
		addr_t addr;
	} mem_read_req_t;

	// read response, valid one cycle after the request
	typedef struct packed {
		logic valid;
		word_t data;
	} mem_read_rsp_t;

endpackage

//--- verilog/dma_consts.svh
`ifndef DMA_CONSTS_SVH
`define DMA_CONSTS_SVH

// data and address width in bits
`define DMA_WORD_SIZE 16

// number of words held by the memory
// byte addresses wrap around this depth
`define DMA_MEM_DEPTH 256

// device buffer words, also the longest burst
`define DMA_DEV_DEPTH 16

// cycles from the first write strobe cycle to the acknowledge pulse
`define DMA_WRITE_LATENCY 2

`endif

//--- verilog/dma_controller.sv
module dma_controller (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   cpu_valid,
	input  dma_ctrl_pkg::dma_cmd_t cpu_cmd,
	input  logic                   bus_grant,
	input  logic                   write_ack,
	output logic                   bus_request,
	output logic                   ex_valid,
	output dma_ctrl_pkg::offset_t  offset,
	output dma_bus_pkg::addr_t     dma_address,
	output logic                   interrupt
);

	dma_ctrl_pkg::ctrl_state_e state;
	// latched command, only taken in idle
	dma_ctrl_pkg::dma_cmd_t cmd_q;
	dma_bus_pkg::addr_t word_count;
	dma_ctrl_pkg::offset_t last_offset;

	// words in the burst and the offset of the final one
	assign word_count = cmd_q.length >> 2;
	assign last_offset = dma_ctrl_pkg::offset_t'(word_count - 1'b1);

	// byte address of the current word
	assign dma_address = cmd_q.start_addr + (dma_bus_pkg::addr_t'(offset) << 2);

	// command latch, a command outside idle is dropped
	always_ff @(posedge clk) begin
		if (state == dma_ctrl_pkg::state_idle && cpu_valid) begin
			cmd_q <= cpu_cmd;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= dma_ctrl_pkg::state_idle;
			bus_request <= 1'b0;
			ex_valid <= 1'b0;
			offset <= '0;
			interrupt <= 1'b0;
		end else begin
			case (state)
				dma_ctrl_pkg::state_idle: begin
					// interrupt pulse ends here
					interrupt <= 1'b0;
					if (cpu_valid) begin
						bus_request <= 1'b1;
						state <= dma_ctrl_pkg::state_request;
					end
				end
				dma_ctrl_pkg::state_request: begin
					// first granted cycle starts the device at word zero
					if (bus_grant) begin
						ex_valid <= 1'b1;
						offset <= '0;
						state <= dma_ctrl_pkg::state_transfer;
					end
				end
				dma_ctrl_pkg::state_transfer: begin
					// offset and write held until memory acknowledges
					if (write_ack) begin
						if (offset == last_offset) begin
							ex_valid <= 1'b0;
							bus_request <= 1'b0;
							state <= dma_ctrl_pkg::state_release;
						end else begin
							offset <= offset + 1'b1;
						end
					end
				end
				dma_ctrl_pkg::state_release: begin
					// wait for the arbiter to take the grant back
					if (!bus_grant) begin
						interrupt <= 1'b1;
						state <= dma_ctrl_pkg::state_idle;
					end
				end
				default: begin
					state <= dma_ctrl_pkg::state_idle;
				end
			endcase
		end
	end

	// device only drives while the arbiter has handed over the bus
	a_ex_valid_granted: assert property (@(posedge clk) disable iff (!reset_n)
		ex_valid |-> bus_grant);

	// walk stays inside the commanded burst
	a_offset_in_burst: assert property (@(posedge clk) disable iff (!reset_n)
		ex_valid |-> offset <= last_offset);

	a_interrupt_pulse: assert property (@(posedge clk) disable iff (!reset_n)
		interrupt |=> !interrupt);

endmodule

//--- verilog/dma_ctrl_pkg.sv
`include "dma_consts.svh"

package dma_ctrl_pkg;

	// command from the cpu side, both fields in bytes
	// length is a multiple of 4 and at most 4 * device depth
	typedef struct packed {
		dma_bus_pkg::addr_t start_addr;
		dma_bus_pkg::addr_t length;
	} dma_cmd_t;

	// word offset inside a burst, indexes the device buffer
	typedef logic [$clog2(`DMA_DEV_DEPTH)-1:0] offset_t;

	// controller states
	typedef enum logic [1:0] {
		state_idle,
		state_request,
		state_transfer,
		state_release
	} ctrl_state_e;

endpackage

//--- verilog/dma_subsystem.sv
module dma_subsystem (
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic                       cpu_valid,
	input  dma_ctrl_pkg::dma_cmd_t     cpu_cmd,
	input  logic                       cpu_hold,
	input  dma_bus_pkg::mem_read_req_t cpu_read,
	input  logic                       dev_load,
	input  dma_ctrl_pkg::offset_t      dev_index,
	input  dma_bus_pkg::word_t         dev_load_data,
	output logic                       interrupt,
	output logic                       bus_request,
	output dma_bus_pkg::mem_read_rsp_t cpu_rdata
);

	logic bus_grant;
	logic write_ack;
	logic ex_valid;
	dma_ctrl_pkg::offset_t offset;
	dma_bus_pkg::addr_t dma_address;
	dma_bus_pkg::word_t dev_data;
	// arbitrated memory requests
	dma_bus_pkg::mem_write_t mem_wr;
	dma_bus_pkg::mem_read_req_t mem_rd;

	dma_controller u_dma_controller (
		.clk         (clk),
		.reset_n     (reset_n),
		.cpu_valid   (cpu_valid),
		.cpu_cmd     (cpu_cmd),
		.bus_grant   (bus_grant),
		.write_ack   (write_ack),
		.bus_request (bus_request),
		.ex_valid    (ex_valid),
		.offset      (offset),
		.dma_address (dma_address),
		.interrupt   (interrupt)
	);

	bus_arbiter u_bus_arbiter (
		.clk         (clk),
		.reset_n     (reset_n),
		.bus_request (bus_request),
		.cpu_hold    (cpu_hold),
		.ex_valid    (ex_valid),
		.dma_address (dma_address),
		.dev_data    (dev_data),
		.cpu_read    (cpu_read),
		.bus_grant   (bus_grant),
		.mem_wr      (mem_wr),
		.mem_rd      (mem_rd)
	);

	ext_device u_ext_device (
		.clk           (clk),
		.reset_n       (reset_n),
		.dev_load      (dev_load),
		.dev_index     (dev_index),
		.dev_load_data (dev_load_data),
		.ex_valid      (ex_valid),
		.offset        (offset),
		.dev_data      (dev_data)
	);

	word_memory u_word_memory (
		.clk       (clk),
		.reset_n   (reset_n),
		.mem_wr    (mem_wr),
		.mem_rd    (mem_rd),
		.write_ack (write_ack),
		.cpu_rdata (cpu_rdata)
	);

endmodule

//--- verilog/ext_device.sv
`include "dma_consts.svh"

module ext_device (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  dev_load,
	input  dma_ctrl_pkg::offset_t dev_index,
	input  dma_bus_pkg::word_t    dev_load_data,
	input  logic                  ex_valid,
	input  dma_ctrl_pkg::offset_t offset,
	output dma_bus_pkg::word_t    dev_data
);

	// word buffer filled from outside before a burst
	dma_bus_pkg::word_t buffer [`DMA_DEV_DEPTH];

	// load port, one word per strobe
	always_ff @(posedge clk) begin
		if (dev_load) begin
			buffer[dev_index] <= dev_load_data;
		end
	end

	// present the selected word only while the controller asks for it
	always_comb begin
		if (ex_valid) begin
			dev_data = buffer[offset];
		end else begin
			dev_data = '0;
		end
	end

	// buffer contents must not change under a running burst
	a_no_load_in_burst: assert property (@(posedge clk) disable iff (!reset_n)
		ex_valid |-> !dev_load);

endmodule

//--- verilog/word_memory.sv
`include "dma_consts.svh"

module word_memory (
	input  logic                       clk,
	input  logic                       reset_n,
	input  dma_bus_pkg::mem_write_t    mem_wr,
	input  dma_bus_pkg::mem_read_req_t mem_rd,
	output logic                       write_ack,
	output dma_bus_pkg::mem_read_rsp_t cpu_rdata
);

	localparam int idx_w = $clog2(`DMA_MEM_DEPTH);
	localparam int cnt_w = $clog2(`DMA_WRITE_LATENCY + 1);
	localparam int lat_last = `DMA_WRITE_LATENCY - 1;

	dma_bus_pkg::word_t mem [`DMA_MEM_DEPTH];
	// cycles already spent on the pending write
	logic [cnt_w-1:0] wr_count;
	logic [idx_w-1:0] wr_index;
	logic [idx_w-1:0] rd_index;

	// byte address to word index, upper bits drop so addresses wrap
	assign wr_index = mem_wr.addr[idx_w+1:2];
	assign rd_index = mem_rd.addr[idx_w+1:2];

	// write timing and storage
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wr_count <= '0;
			write_ack <= 1'b0;
			for (int i = 0; i < `DMA_MEM_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else begin
			write_ack <= 1'b0;
			// during the ack cycle the strobe is still up, no new write yet
			if (mem_wr.wr_en && !write_ack) begin
				if (wr_count == lat_last) begin
					mem[wr_index] <= mem_wr.data;
					write_ack <= 1'b1;
					wr_count <= '0;
				end else begin
					wr_count <= wr_count + 1'b1;
				end
			end
		end
	end

	// one cycle read response
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			cpu_rdata.valid <= 1'b0;
		end else begin
			cpu_rdata.valid <= mem_rd.rd_en;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_rd.rd_en) begin
			cpu_rdata.data <= mem[rd_index];
		end
	end

	// the master keeps the write steady until it sees the ack
	a_write_stable: assert property (@(posedge clk) disable iff (!reset_n)
		(wr_count != 0) |-> mem_wr.wr_en && $stable(mem_wr.addr) && $stable(mem_wr.data));

endmodule
